// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := ste_periph_tb
FILELIST   := sim.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
LOG        := sim.log
FAIL_MSG   := STATUS: FAIL
PASS_MSG   := STATUS: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== rtl/pad_if.sv ====
// joypad link: host word and select lines in, key and button lines out
`timescale 1ns/10ps

interface pad_if;
	import ste_device_pkg::*;

	// host joystick bits for this port
	logic [joy_w-1:0] joy;
	// active low group selects
	logic [pad_sel_w-1:0] sel;
	// active low key lines
	logic [pad_key_w-1:0] keys;
	// active low fire and pause
	logic [pad_btn_w-1:0] buttons;

	modport ctrl_mp (output joy, output sel);
	modport pad_mp (input joy, input sel, output keys, output buttons);
	modport read_mp (input keys, input buttons);

endinterface

// ==== rtl/pad_port_ctrl.sv ====
// joypad port controller: select latch, output enable and host stick routing
`timescale 1ns/10ps

module pad_port_ctrl (
	input  logic                                clk_32,
	input  logic                                xsint,
	input  logic                                ste_port_en_i,
	input  logic [ste_device_pkg::joy_w-1:0]    joy0_i,
	input  logic [ste_device_pkg::joy_w-1:0]    joy1_i,
	input  logic                                joy_wl_i,
	input  logic                                joy_we_n_i,
	input  logic [periph_bus_pkg::data_w/2-1:0] wr_data_i,
	output logic [periph_bus_pkg::data_w/2-1:0] sel_latch_o,
	pad_if.ctrl_mp                              pads [ste_device_pkg::num_pads]
);
	import periph_bus_pkg::*;
	import ste_device_pkg::*;

	logic [data_w/2-1:0] sel_latch;
	logic [joy_w-1:0]    joy_route [num_pads];

	// select lines written by the cpu, all high deselects every group
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			sel_latch <= '1;
		end else if (joy_wl_i) begin
			sel_latch <= wr_data_i;
		end
	end

	// read back on the low byte lane
	assign sel_latch_o = sel_latch;

	// ports are crossed: pad 0 is fed from host stick 1
	// with the ports off the pads see an idle stick
	assign joy_route[0] = ste_port_en_i ? joy1_i : '0;
	assign joy_route[1] = ste_port_en_i ? joy0_i : '0;

	for (genvar p = 0; p < num_pads; p++) begin : g_pad
		assign pads[p].joy = joy_route[p];
		// latch only reaches the pins while output enable is low
		assign pads[p].sel = joy_we_n_i ? '1 : sel_latch[p*pad_sel_w +: pad_sel_w];
	end

endmodule

// ==== rtl/periph_bus_pkg.sv ====
// peripheral bus package: bus widths, register codes and read fill patterns
package periph_bus_pkg;

	// cpu data bus
	localparam int data_w = 16;

	// register select taken from address bits 4 to 1
	localparam int reg_addr_w = 4;

	// rp5c15 control registers, shared by both banks
	// bank select, bit 0 holds the bank
	localparam logic [reg_addr_w-1:0] rtc_bank_reg = 4'd13;
	// test register
	localparam logic [reg_addr_w-1:0] rtc_test_reg = 4'd14;
	// reset register
	localparam logic [reg_addr_w-1:0] rtc_reset_reg = 4'd15;

	// idle byte lane
	localparam logic [data_w/2-1:0] byte_fill = 8'hff;

	// undriven upper bits above a nibble read
	localparam logic [data_w-5:0] nibble_fill = 12'hfff;

endpackage

// ==== rtl/periph_read_mux.sv ====
// peripheral read mux: buttons, joypad byte lanes and clock nibble onto the bus
`timescale 1ns/10ps

module periph_read_mux (
	pad_if.read_mp                              pads [ste_device_pkg::num_pads],
	input  logic [periph_bus_pkg::data_w/2-1:0] sel_latch_i,
	input  logic [3:0]                          rtc_data_i,
	input  logic                                button_n_i,
	input  logic                                joy_rl_n_i,
	input  logic                                joy_rh_n_i,
	input  logic                                rtc_cs_n_i,
	output logic [periph_bus_pkg::data_w-1:0]   rd_data_o
);
	import periph_bus_pkg::*;
	import ste_device_pkg::*;

	logic [num_pads*pad_key_w-1:0] keys_all;
	logic [num_pads*pad_btn_w-1:0] btn_all;

	// pad 0 in the low bits
	for (genvar p = 0; p < num_pads; p++) begin : g_gather
		assign keys_all[p*pad_key_w +: pad_key_w] = pads[p].keys;
		assign btn_all[p*pad_btn_w +: pad_btn_w] = pads[p].buttons;
	end

	// buttons win, then joypad lanes, then clock
	always_comb begin
		if (!button_n_i) begin
			rd_data_o = {nibble_fill, btn_all};
		end else if (!(joy_rl_n_i & joy_rh_n_i)) begin
			// unread lane floats high
			rd_data_o[data_w-1:data_w/2] = joy_rh_n_i ? byte_fill : keys_all;
			rd_data_o[data_w/2-1:0] = joy_rl_n_i ? byte_fill : sel_latch_i;
		end else if (!rtc_cs_n_i) begin
			rd_data_o = {nibble_fill, rtc_data_i};
		end else begin
			rd_data_o = '1;
		end
	end

endmodule

// ==== rtl/rtc_rp5c15.sv ====
// rp5c15 clock: bank 0 time decode, bank bit and bank 1 scratch nibbles
`timescale 1ns/10ps

module rtc_rp5c15 (
	input  logic                                  clk_32,
	input  logic                                  xsint,
	input  logic [ste_device_pkg::time_w-1:0]     time_i,
	input  logic [periph_bus_pkg::reg_addr_w-1:0] a_i,
	input  logic [3:0]                            wr_data_i,
	input  logic                                  rtc_cs_n_i,
	input  logic                                  rtc_wr_n_i,
	output logic [3:0]                            rtc_data_o
);
	import periph_bus_pkg::*;
	import ste_device_pkg::*;

	logic       bank;
	logic [3:0] scratch [2**reg_addr_w];
	logic       wr_en;

	// chip select and write strobe both low
	assign wr_en = ~(rtc_cs_n_i | rtc_wr_n_i);

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			bank <= 1'b0;
		end else if (wr_en && (a_i == rtc_bank_reg)) begin
			bank <= wr_data_i[0];
		end
	end

	// every other register lands in the scratch file
	always_ff @(posedge clk_32) begin
		if (wr_en && (a_i != rtc_bank_reg)) begin
			scratch[a_i] <= wr_data_i;
		end
	end

	always_comb begin
		if (a_i == rtc_bank_reg) begin
			// mode register, timer enable bit reads set
			rtc_data_o = {3'b100, bank};
		end else if (a_i == rtc_test_reg) begin
			rtc_data_o = 4'h0;
		end else if (a_i == rtc_reset_reg) begin
			rtc_data_o = 4'hc;
		end else if (bank) begin
			rtc_data_o = scratch[a_i];
		end else begin
			case (a_i)
				4'd0: rtc_data_o = time_i[sec_lo +: 4];
				4'd1: rtc_data_o = time_i[sec_hi +: 4];
				4'd2: rtc_data_o = time_i[min_lo +: 4];
				4'd3: rtc_data_o = time_i[min_hi +: 4];
				4'd4: rtc_data_o = time_i[hour_lo +: 4];
				4'd5: rtc_data_o = time_i[hour_hi +: 4];
				4'd6: rtc_data_o = time_i[wday_lo +: 4];
				4'd7: rtc_data_o = time_i[day_lo +: 4];
				4'd8: rtc_data_o = time_i[day_hi +: 4];
				4'd9: rtc_data_o = time_i[mon_lo +: 4];
				4'd10: rtc_data_o = time_i[mon_hi +: 4];
				4'd11: rtc_data_o = time_i[year_lo +: 4];
				// wraps modulo 16
				4'd12: rtc_data_o = time_i[year_hi +: 4] + year_offset;
				default: rtc_data_o = 4'hf;
			endcase
		end
	end

endmodule

// ==== rtl/ste_device_pkg.sv ====
// ste device package: joypad port sizes and rp5c15 time word layout
package ste_device_pkg;

	// enhanced joypad ports on the ste
	localparam int num_pads = 2;
	// host joystick word
	localparam int joy_w = 16;
	// select lines per pad, one per key group
	localparam int pad_sel_w = 4;
	// returned key lines per pad
	localparam int pad_key_w = 4;
	// fire and pause lines per pad
	localparam int pad_btn_w = 2;

	// host time word, bcd nibbles
	localparam int time_w = 64;
	// tos counts years from 1980
	localparam logic [3:0] year_offset = 4'd2;

	// nibble offsets in the time word
	localparam int sec_lo = 0;
	localparam int sec_hi = 4;
	localparam int min_lo = 8;
	localparam int min_hi = 12;
	localparam int hour_lo = 16;
	localparam int hour_hi = 20;
	localparam int day_lo = 24;
	localparam int day_hi = 28;
	localparam int mon_lo = 32;
	localparam int mon_hi = 36;
	localparam int year_lo = 40;
	localparam int year_hi = 44;
	// weekday overlaps the top of the year field
	localparam int wday_lo = 45;

	// host word bits routed to the button lines
	localparam int fire_bit = 4;
	localparam int pause_bit = 8;

endpackage

// ==== rtl/ste_joypad.sv ====
// ste enhanced joypad: key group matrix and fire and pause lines
`timescale 1ns/10ps

module ste_joypad (
	pad_if.pad_mp pad
);
	import ste_device_pkg::*;

	logic [pad_key_w-1:0] hit;

	// or together every selected group
	// group k is bits 4k to 4k+3 of the host word
	always_comb begin
		hit = '0;
		for (int k = 0; k < pad_sel_w; k++) begin
			if (!pad.sel[k]) begin
				hit = hit | pad.joy[k*pad_key_w +: pad_key_w];
			end
		end
	end

	// pressed keys pull the lines low
	assign pad.keys = ~hit;

	// fire on select 0, pause on select 1
	assign pad.buttons[0] = ~(~pad.sel[0] & pad.joy[fire_bit]);
	assign pad.buttons[1] = ~(~pad.sel[1] & pad.joy[pause_bit]);

endmodule

// ==== rtl/ste_periph_top.sv ====
// ste extended peripherals: two enhanced joypad ports and the rp5c15 clock
`timescale 1ns/10ps

module ste_periph_top (
	input  logic                                  clk_32,
	input  logic                                  xsint,
	input  logic                                  ste_port_en_i,
	input  logic [ste_device_pkg::joy_w-1:0]      joy0_i,
	input  logic [ste_device_pkg::joy_w-1:0]      joy1_i,
	input  logic [ste_device_pkg::time_w-1:0]     time_i,
	input  logic [periph_bus_pkg::reg_addr_w-1:0] a_i,
	input  logic [periph_bus_pkg::data_w-1:0]     wr_data_i,
	input  logic                                  joy_wl_i,
	input  logic                                  joy_we_n_i,
	input  logic                                  joy_rl_n_i,
	input  logic                                  joy_rh_n_i,
	input  logic                                  button_n_i,
	input  logic                                  rtc_cs_n_i,
	input  logic                                  rtc_wr_n_i,
	output logic [periph_bus_pkg::data_w-1:0]     rd_data_o
);
	import periph_bus_pkg::*;
	import ste_device_pkg::*;

	logic [data_w/2-1:0] sel_latch;
	logic [3:0]          rtc_data;

	// one link per port
	pad_if pads [num_pads] ();

	// select latch sits on the low byte lane
	pad_port_ctrl u_port_ctrl (
		.clk_32        (clk_32),
		.xsint         (xsint),
		.ste_port_en_i (ste_port_en_i),
		.joy0_i        (joy0_i),
		.joy1_i        (joy1_i),
		.joy_wl_i      (joy_wl_i),
		.joy_we_n_i    (joy_we_n_i),
		.wr_data_i     (wr_data_i[data_w/2-1:0]),
		.sel_latch_o   (sel_latch),
		.pads          (pads)
	);

	for (genvar p = 0; p < num_pads; p++) begin : g_pads
		ste_joypad u_pad (
			.pad (pads[p])
		);
	end

	// clock registers are four bits wide
	rtc_rp5c15 u_rtc (
		.clk_32     (clk_32),
		.xsint      (xsint),
		.time_i     (time_i),
		.a_i        (a_i),
		.wr_data_i  (wr_data_i[3:0]),
		.rtc_cs_n_i (rtc_cs_n_i),
		.rtc_wr_n_i (rtc_wr_n_i),
		.rtc_data_o (rtc_data)
	);

	periph_read_mux u_read_mux (
		.pads        (pads),
		.sel_latch_i (sel_latch),
		.rtc_data_i  (rtc_data),
		.button_n_i  (button_n_i),
		.joy_rl_n_i  (joy_rl_n_i),
		.joy_rh_n_i  (joy_rh_n_i),
		.rtc_cs_n_i  (rtc_cs_n_i),
		.rd_data_o   (rd_data_o)
	);

endmodule

// ==== sim.f ====
rtl/periph_bus_pkg.sv
rtl/ste_device_pkg.sv
rtl/pad_if.sv
rtl/pad_port_ctrl.sv
rtl/ste_joypad.sv
rtl/rtc_rp5c15.sv
rtl/periph_read_mux.sv
rtl/ste_periph_top.sv
verif/ste_periph_assertions.sv
verif/ste_periph_tb.sv

// ==== verif/ste_periph_assertions.sv ====
// ste peripheral port assertions: fill patterns and idle pads after reset
`timescale 1ns/10ps

module ste_periph_assertions (
	input logic                              clk_32,
	input logic                              xsint,
	input logic                              joy_wl_i,
	input logic                              joy_rl_n_i,
	input logic                              joy_rh_n_i,
	input logic                              button_n_i,
	input logic                              rtc_cs_n_i,
	input logic [periph_bus_pkg::data_w-1:0] rd_data_o
);
	int   fail_cnt = 0;
	// set once the select latch has been written
	logic latch_seen;

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) latch_seen <= 1'b0;
		else if (joy_wl_i) latch_seen <= 1'b1;
	end

	// upper nibble undriven on a button read
	a_btn_fill: assert property (@(posedge clk_32) disable iff (!xsint)
		!button_n_i |-> rd_data_o[15:12] == 4'hf)
		else begin
			fail_cnt++;
			$error("button read drives the upper nibble");
		end

	a_idle_bus: assert property (@(posedge clk_32) disable iff (!xsint)
		(button_n_i && joy_rl_n_i && joy_rh_n_i && rtc_cs_n_i) |-> rd_data_o == '1)
		else begin
			fail_cnt++;
			$error("bus driven with no read strobe");
		end

	// reset latch deselects every key group
	a_pads_idle: assert property (@(posedge clk_32) disable iff (!xsint)
		(!latch_seen && button_n_i && !joy_rh_n_i) |-> rd_data_o[15:8] == 8'hff)
		else begin
			fail_cnt++;
			$error("key pressed with pads deselected");
		end

endmodule

bind ste_periph_top ste_periph_assertions u_assertions (.*);

// ==== verif/ste_periph_tb.sv ====
// ste peripheral testbench driving seeded random bus traffic against a reference model
`timescale 1ns/10ps

module ste_periph_tb;
	import periph_bus_pkg::*;
	import ste_device_pkg::*;

	// test lengths in loop iterations
	localparam int n_latch = 100;
	localparam int n_pad = 300;
	localparam int n_time = 20;
	localparam int n_scratch = 64;
	localparam int n_mix = 760;
	// reset, idle reads and the fixed bank writes included
	localparam int test_cycles = 12 + 2*n_latch + 2*n_pad + 16*n_time + n_scratch + 19 + n_mix;
	localparam int timeout_cycles = test_cycles * 3 / 2;

	logic                  clk_32;
	logic                  xsint;
	logic                  ste_port_en_i;
	logic [joy_w-1:0]      joy0_i;
	logic [joy_w-1:0]      joy1_i;
	logic [time_w-1:0]     time_i;
	logic [reg_addr_w-1:0] a_i;
	logic [data_w-1:0]     wr_data_i;
	logic                  joy_wl_i;
	logic                  joy_we_n_i;
	logic                  joy_rl_n_i;
	logic                  joy_rh_n_i;
	logic                  button_n_i;
	logic                  rtc_cs_n_i;
	logic                  rtc_wr_n_i;
	logic [data_w-1:0]     rd_data_o;

	// reference model state
	logic [7:0] m_latch;
	logic       m_bank;
	logic [3:0] m_scratch [16];
	logic       m_written [16];
	// bank 0 nibble positions in the time word for registers 0 to 12
	int         nib_off [13] = '{0, 4, 8, 12, 16, 20, 45, 24, 28, 32, 36, 40, 44};
	integer     seed;
	int         cycle_cnt = 0;
	logic [31:0] r;
	logic [31:0] q;

	ste_periph_top u_dut (.*);

	initial begin
		clk_32 = 1'b0;
		forever #5 clk_32 = ~clk_32;
	end

	// hard stop well past the expected run length
	always @(posedge clk_32) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= timeout_cycles) begin
			$display("error: timeout, test did not finish within %0d cycles", timeout_cycles);
			$display("STATUS: FAIL");
			$fatal(1, "timeout");
		end
	end

	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	// expected {buttons, keys} seen on pad p
	function automatic logic [5:0] pad_lines(input int p);
		logic [15:0] host;
		logic [3:0]  sel;
		logic [3:0]  keys;
		logic [1:0]  btn;
		// ports cross over and disabled ports read as an idle stick
		if (!ste_port_en_i) host = '0;
		else if (p == 0) host = joy1_i;
		else host = joy0_i;
		sel = joy_we_n_i ? 4'hf : m_latch[4*p +: 4];
		keys = 4'hf;
		for (int g = 0; g < 4; g++) begin
			for (int j = 0; j < 4; j++) begin
				if (!sel[g] && host[4*g+j]) keys[j] = 1'b0;
			end
		end
		btn[0] = !(!sel[0] && host[4]);
		btn[1] = !(!sel[1] && host[8]);
		return {btn, keys};
	endfunction

	// {known, nibble} for the register on a_i
	function automatic logic [4:0] rtc_expect();
		logic [3:0] v;
		logic       known;
		known = 1'b1;
		if (a_i == 4'd13) v = m_bank ? 4'd9 : 4'd8;
		else if (a_i == 4'd14) v = 4'd0;
		else if (a_i == 4'd15) v = 4'd12;
		else if (m_bank) begin
			v = m_scratch[a_i];
			known = m_written[a_i];
		end else begin
			v = time_i[nib_off[a_i] +: 4];
			// os counts years from 1980
			if (a_i == 4'd12) v = v + 4'd2;
		end
		return {known, v};
	endfunction

	// {low nibble valid, read word} from the read priority rules
	function automatic logic [16:0] expect_rd();
		logic [5:0]  p0;
		logic [5:0]  p1;
		logic [4:0]  nib;
		logic [15:0] d;
		logic        care;
		p0 = pad_lines(0);
		p1 = pad_lines(1);
		nib = rtc_expect();
		care = 1'b1;
		d = 16'hffff;
		if (!button_n_i) d = {12'hfff, p1[5:4], p0[5:4]};
		else if (!joy_rl_n_i || !joy_rh_n_i) begin
			if (!joy_rh_n_i) d[15:8] = {p1[3:0], p0[3:0]};
			if (!joy_rl_n_i) d[7:0] = m_latch;
		end else if (!rtc_cs_n_i) begin
			d = {12'hfff, nib[3:0]};
			care = nib[4];
		end
		return {care, d};
	endfunction

	task automatic compare(input string name, input logic [15:0] exp_v,
	                       input logic [15:0] act_v);
		if (act_v !== exp_v) begin
			$display("error: time %0t: %s expected %h got %h", $time, name, exp_v, act_v);
			$display("STATUS: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	// wait for the rising edge and drop every strobe
	task automatic next_cycle();
		@(posedge clk_32);
		joy_wl_i <= 1'b0;
		joy_rl_n_i <= 1'b1;
		joy_rh_n_i <= 1'b1;
		button_n_i <= 1'b1;
		rtc_cs_n_i <= 1'b1;
		rtc_wr_n_i <= 1'b1;
	endtask

	// check mid cycle and commit writes that land on the next edge
	task automatic check_cycle();
		logic [16:0] e;
		@(negedge clk_32);
		e = expect_rd();
		if (e[16]) compare("rd_data_o", e[15:0], rd_data_o);
		else compare("rd_data_o[15:4]", {4'h0, e[15:4]}, {4'h0, rd_data_o[15:4]});
		if (joy_wl_i) m_latch = wr_data_i[7:0];
		if (!rtc_cs_n_i && !rtc_wr_n_i) begin
			if (a_i == 4'd13) m_bank = wr_data_i[0];
			else begin
				m_scratch[a_i] = wr_data_i[3:0];
				m_written[a_i] = 1'b1;
			end
		end
	endtask

	initial begin
		seed = 32'h7fe4_c6d5;
		xsint = 1'b0;
		ste_port_en_i = 1'b1;
		joy0_i = '0;
		joy1_i = '0;
		time_i = '0;
		a_i = '0;
		wr_data_i = '0;
		joy_wl_i = 1'b0;
		joy_we_n_i = 1'b0;
		joy_rl_n_i = 1'b1;
		joy_rh_n_i = 1'b1;
		button_n_i = 1'b1;
		rtc_cs_n_i = 1'b1;
		rtc_wr_n_i = 1'b1;
		m_latch = 8'hff;
		m_bank = 1'b0;
		for (int i = 0; i < 16; i++) m_written[i] = 1'b0;
		repeat (10) @(posedge clk_32);
		xsint <= 1'b1;

		// idle pads after reset with busy host sticks
		next_cycle();
		joy0_i <= 16'hffff;
		joy1_i <= 16'hffff;
		button_n_i <= 1'b0;
		check_cycle();
		next_cycle();
		joy_rh_n_i <= 1'b0;
		check_cycle();

		// latch write then low byte readback
		for (int i = 0; i < n_latch; i++) begin
			next_cycle();
			r = rand32();
			joy_wl_i <= 1'b1;
			wr_data_i <= r[15:0];
			check_cycle();
			next_cycle();
			joy_rl_n_i <= 1'b0;
			check_cycle();
		end

		// key groups and buttons across routing and enable levels
		for (int i = 0; i < n_pad; i++) begin
			next_cycle();
			r = rand32();
			q = rand32();
			joy0_i <= q[15:0];
			joy1_i <= q[31:16];
			ste_port_en_i <= r[16];
			joy_we_n_i <= r[17] & r[18];
			joy_wl_i <= 1'b1;
			wr_data_i <= r[15:0];
			check_cycle();
			next_cycle();
			button_n_i <= r[20];
			joy_rh_n_i <= r[21];
			joy_rl_n_i <= r[22];
			check_cycle();
		end

		// bank 0 time decode over every register
		for (int i = 0; i < n_time; i++) begin
			for (int a = 0; a < 16; a++) begin
				next_cycle();
				// fresh time word at the start of each pass
				if (a == 0) time_i <= {rand32(), rand32()};
				a_i <= 4'(a);
				rtc_cs_n_i <= 1'b0;
				check_cycle();
			end
		end

		// bank 1 scratch file
		next_cycle();
		r = rand32();
		a_i <= 4'd13;
		wr_data_i <= {r[15:1], 1'b1};
		rtc_cs_n_i <= 1'b0;
		rtc_wr_n_i <= 1'b0;
		check_cycle();
		for (int i = 0; i < n_scratch; i++) begin
			next_cycle();
			r = rand32();
			a_i <= 4'(r[7:0] % 13);
			wr_data_i <= r[31:16];
			rtc_cs_n_i <= 1'b0;
			rtc_wr_n_i <= 1'b0;
			check_cycle();
		end
		for (int a = 0; a < 16; a++) begin
			next_cycle();
			a_i <= 4'(a);
			rtc_cs_n_i <= 1'b0;
			check_cycle();
		end
		// back to bank 0 as seen through register 13
		next_cycle();
		a_i <= 4'd13;
		wr_data_i <= 16'h0000;
		rtc_cs_n_i <= 1'b0;
		rtc_wr_n_i <= 1'b0;
		check_cycle();
		next_cycle();
		a_i <= 4'd13;
		rtc_cs_n_i <= 1'b0;
		check_cycle();

		// every strobe at random with most low about a quarter of the time
		for (int i = 0; i < n_mix; i++) begin
			next_cycle();
			r = rand32();
			q = rand32();
			button_n_i <= (r[1:0] != 2'd0);
			joy_rl_n_i <= (r[3:2] != 2'd0);
			joy_rh_n_i <= (r[5:4] != 2'd0);
			rtc_cs_n_i <= (r[7:6] != 2'd0);
			rtc_wr_n_i <= r[8];
			joy_wl_i <= (r[10:9] == 2'd0);
			joy_we_n_i <= r[11];
			ste_port_en_i <= r[12];
			a_i <= r[23:20];
			wr_data_i <= q[31:16];
			joy0_i <= q[15:0];
			joy1_i <= {q[7:0], r[31:24]};
			if (r[13]) time_i <= {rand32(), rand32()};
			check_cycle();
		end

		@(posedge clk_32);
		if (u_dut.u_assertions.fail_cnt == 0) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			$display("error: %0d assertion failures", u_dut.u_assertions.fail_cnt);
			$display("STATUS: FAIL");
			$fatal(1, "assertion failures");
		end
	end

endmodule
